/* compile.f */
logic/rv_pkg.sv
logic/rv_decoder.sv
logic/rv_imm_gen.sv
logic/rv_alu.sv
logic/rv_branch_unit.sv
logic/rv_regfile.sv
logic/rv_core.sv
tb/rv_core_sva.sv
tb/tb_rv_core.sv

/* logic/rv_alu.sv */
module rv_alu (
	input  rv_pkg::alu_op_e op,
	input  rv_pkg::word_t   a,
	input  rv_pkg::word_t   b,
	output rv_pkg::word_t   result
);
	import rv_pkg::*;

	logic               sub_mode;
	word_t              b_addend;
	word_t              sum;
	logic [SHAMT_W-1:0] shamt;
	logic               lt_signed;
	logic               lt_unsigned;

	// Bit 3 picks subtract; sra and pass_b ignore the sum
	assign sub_mode = op[3];
	assign b_addend = sub_mode ? ~b : b;
	assign sum      = a + b_addend + word_t'(sub_mode);	// One adder for add and sub

	assign shamt = b[SHAMT_W-1:0];

	assign lt_signed   = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb begin
		case (op)
			alu_add,
			alu_sub:    result = sum;
			alu_sll:    result = a << shamt;
			alu_slt:    result = word_t'(lt_signed);
			alu_sltu:   result = word_t'(lt_unsigned);
			alu_xor:    result = a ^ b;
			alu_srl:    result = a >> shamt;
			alu_sra:    result = word_t'($signed(a) >>> shamt);	// Sign fill
			alu_or:     result = a | b;
			alu_and:    result = a & b;
			alu_pass_b: result = b;
			default:    result = '0;
		endcase
	end

endmodule

/* logic/rv_branch_unit.sv */
module rv_branch_unit (
	input  rv_pkg::branch_op_e op,
	input  rv_pkg::word_t      rs1_data,
	input  rv_pkg::word_t      rs2_data,
	output logic               taken
);
	import rv_pkg::*;

	logic [XLEN:0] diff;	// Extra bit holds the borrow
	logic          equal;
	logic          lt_unsigned;
	logic          lt_signed;
	logic          signs_differ;

	assign diff         = {1'b0, rs1_data} - {1'b0, rs2_data};
	assign equal        = (diff[XLEN-1:0] == '0);
	assign lt_unsigned  = diff[XLEN];	// Borrow out
	assign signs_differ = rs1_data[XLEN-1] ^ rs2_data[XLEN-1];

	// Mixed signs: the negative operand is smaller
	assign lt_signed = signs_differ ? rs1_data[XLEN-1] : diff[XLEN-1];

	always_comb begin
		case (op)
			br_beq:  taken = equal;
			br_bne:  taken = !equal;
			br_blt:  taken = lt_signed;
			br_bge:  taken = !lt_signed;
			br_bltu: taken = lt_unsigned;
			br_bgeu: taken = !lt_unsigned;
			default: taken = 1'b0;	// funct3 2 and 3 never branch
		endcase
	end

endmodule

/* logic/rv_core.sv */
module rv_core (
	input  logic             clk,
	input  logic             rst,
	input  rv_pkg::inst_t    inst,
	input  logic             inst_valid,
	output rv_pkg::word_t    pc,
	output logic             retire_valid,
	output rv_pkg::word_t    retire_pc,
	output rv_pkg::word_t    retire_next_pc,
	output logic             retire_rd_we,
	output rv_pkg::reg_idx_t retire_rd,
	output rv_pkg::word_t    retire_rd_data
);
	import rv_pkg::*;

	reg_idx_t   rs1;
	reg_idx_t   rs2;
	reg_idx_t   rd;
	logic       rd_we;
	logic       a_sel_pc;
	logic       b_sel_imm;
	logic       is_jump;
	logic       is_branch;
	imm_type_e  imm_type;
	alu_op_e    alu_op;
	branch_op_e branch_op;
	wb_sel_e    wb_sel;

	word_t rs1_data;
	word_t rs2_data;
	word_t imm;
	word_t op_a;
	word_t op_b;
	word_t alu_result;
	logic  branch_taken;
	logic  take_target;
	word_t pc_plus4;
	word_t jump_target;
	word_t next_pc;
	word_t wb_data;

	rv_decoder u_decoder (
		.inst(inst), .rs1(rs1), .rs2(rs2), .rd(rd), .rd_we(rd_we),
		.a_sel_pc(a_sel_pc), .b_sel_imm(b_sel_imm), .is_jump(is_jump),
		.is_branch(is_branch), .imm_type(imm_type), .alu_op(alu_op),
		.branch_op(branch_op), .wb_sel(wb_sel)
	);

	rv_imm_gen u_imm_gen (.inst(inst), .imm_type(imm_type), .imm(imm));

	rv_regfile u_regfile (
		.clk(clk), .rs1(rs1), .rs2(rs2), .rd(rd),
		.we(rd_we && inst_valid),	// Stall cycles write nothing
		.wdata(wb_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
	);

	rv_alu u_alu (.op(alu_op), .a(op_a), .b(op_b), .result(alu_result));

	rv_branch_unit u_branch (
		.op(branch_op), .rs1_data(rs1_data), .rs2_data(rs2_data), .taken(branch_taken)
	);

	assign op_a = a_sel_pc ? pc : rs1_data;
	assign op_b = b_sel_imm ? imm : rs2_data;

	assign pc_plus4    = pc + INST_BYTES;
	assign take_target = is_jump || (is_branch && branch_taken);
	// JAL and branch targets are already even, so clearing bit 0 only matters for JALR
	assign jump_target = {alu_result[XLEN-1:1], 1'b0};
	assign next_pc     = take_target ? jump_target : pc_plus4;

	assign wb_data = (wb_sel == wb_link) ? pc_plus4 : alu_result;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc           <= RESET_PC;
			retire_valid <= 1'b0;
		end else begin
			retire_valid <= inst_valid;	// One retire per accepted instruction
			if (inst_valid) begin
				pc <= next_pc;
			end
		end
	end

	// Retire record, qualified by retire_valid
	always_ff @(posedge clk) begin
		if (inst_valid) begin
			retire_pc      <= pc;
			retire_next_pc <= next_pc;
			retire_rd_we   <= rd_we;	// Reported even for rd = x0
			retire_rd      <= rd;
			retire_rd_data <= wb_data;
		end
	end

endmodule

/* logic/rv_decoder.sv */
module rv_decoder (
	input  rv_pkg::inst_t      inst,
	output rv_pkg::reg_idx_t   rs1,
	output rv_pkg::reg_idx_t   rs2,
	output rv_pkg::reg_idx_t   rd,
	output logic               rd_we,
	output logic               a_sel_pc,
	output logic               b_sel_imm,
	output logic               is_jump,
	output logic               is_branch,
	output rv_pkg::imm_type_e  imm_type,
	output rv_pkg::alu_op_e    alu_op,
	output rv_pkg::branch_op_e branch_op,
	output rv_pkg::wb_sel_e    wb_sel
);
	import rv_pkg::*;

	opcode_e    opcode;
	logic [2:0] funct3;
	logic       bit30;

	// Shared funct3 decode for the register and immediate ALU groups
	function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt,
			input logic reg_form);
		alu_op_e op;
		op = alu_add;
		case (f3)
			3'b000: op = (alt && reg_form) ? alu_sub : alu_add;	// No subi in the ISA
			3'b001: op = alu_sll;
			3'b010: op = alu_slt;
			3'b011: op = alu_sltu;
			3'b100: op = alu_xor;
			3'b101: op = alt ? alu_sra : alu_srl;	// Both groups
			3'b110: op = alu_or;
			3'b111: op = alu_and;
		endcase
		return op;
	endfunction

	assign opcode = opcode_e'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign bit30  = inst[30];

	// Fixed field positions in every format
	assign rs1 = inst[19:15];
	assign rs2 = inst[24:20];
	assign rd  = inst[11:7];

	assign branch_op = branch_op_e'(funct3);	// Only looked at when is_branch

	always_comb begin
		rd_we     = 1'b0;	// No-op defaults
		a_sel_pc  = 1'b0;
		b_sel_imm = 1'b0;
		is_jump   = 1'b0;
		is_branch = 1'b0;
		imm_type  = imm_i;
		alu_op    = alu_add;
		wb_sel    = wb_alu;
		case (opcode)
			opc_op: begin
				rd_we  = 1'b1;
				alu_op = alu_from_funct(funct3, bit30, 1'b1);
			end
			opc_op_imm: begin
				rd_we     = 1'b1;
				b_sel_imm = 1'b1;
				alu_op    = alu_from_funct(funct3, bit30, 1'b0);
			end
			opc_lui: begin
				rd_we     = 1'b1;
				b_sel_imm = 1'b1;
				imm_type  = imm_u;
				alu_op    = alu_pass_b;
			end
			opc_auipc: begin
				rd_we     = 1'b1;
				a_sel_pc  = 1'b1;
				b_sel_imm = 1'b1;
				imm_type  = imm_u;
			end
			opc_jal: begin
				rd_we     = 1'b1;
				a_sel_pc  = 1'b1;	// Target is pc + offset
				b_sel_imm = 1'b1;
				is_jump   = 1'b1;
				imm_type  = imm_j;
				wb_sel    = wb_link;
			end
			opc_jalr: begin
				rd_we     = 1'b1;
				b_sel_imm = 1'b1;	// Target is rs1 + offset
				is_jump   = 1'b1;
				wb_sel    = wb_link;
			end
			opc_branch: begin
				a_sel_pc  = 1'b1;
				b_sel_imm = 1'b1;
				is_branch = 1'b1;
				imm_type  = imm_b;
			end
			default: begin
				rd_we = 1'b0;	// Unknown opcode falls through as pc + 4
			end
		endcase
	end

endmodule

/* logic/rv_imm_gen.sv */
module rv_imm_gen (
	input  rv_pkg::inst_t     inst,
	input  rv_pkg::imm_type_e imm_type,
	output rv_pkg::word_t     imm
);
	import rv_pkg::*;

	logic sign;

	assign sign = inst[31];	// Sign bit sits at 31 in every format

	always_comb begin
		case (imm_type)
			imm_i: imm = {{20{sign}}, inst[31:20]};
			imm_s: imm = {{20{sign}}, inst[31:25], inst[11:7]};
			imm_b: imm = {{20{sign}}, inst[7], inst[30:25], inst[11:8], 1'b0};
			imm_j: imm = {{12{sign}}, inst[19:12], inst[20], inst[30:21], 1'b0};
			imm_u: imm = {inst[31:12], 12'b0};	// Low 12 bits zero-filled
			default: imm = '0;
		endcase
	end

endmodule

/* logic/rv_pkg.sv */
package rv_pkg;

	localparam int XLEN = 32;	// Data and address width
	localparam int NUM_REGS = 32;	// Architectural registers x0..x31
	localparam int SHAMT_W = $clog2(XLEN);	// Shift amount bits

	typedef logic [XLEN-1:0] word_t;
	typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;
	typedef logic [31:0] inst_t;

	localparam word_t RESET_PC = '0;	// First fetch address
	localparam word_t INST_BYTES = word_t'(4);	// PC step per instruction

	// Major opcodes handled by the core, everything else is a no-op
	typedef enum logic [6:0] {
		opc_op     = 7'b0110011,	// Register-register ALU
		opc_op_imm = 7'b0010011,	// Register-immediate ALU
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111,
		opc_branch = 7'b1100011
	} opcode_e;

	// Bit 3 marks the alternate form (sub, sra)
	typedef enum logic [3:0] {
		alu_add    = 4'b0000,
		alu_sll    = 4'b0001,
		alu_slt    = 4'b0010,
		alu_sltu   = 4'b0011,
		alu_xor    = 4'b0100,
		alu_srl    = 4'b0101,
		alu_or     = 4'b0110,
		alu_and    = 4'b0111,
		alu_sub    = 4'b1000,
		alu_sra    = 4'b1101,
		alu_pass_b = 4'b1111	// LUI
	} alu_op_e;

	typedef enum logic [2:0] {
		imm_i = 3'd0,
		imm_s = 3'd1,
		imm_b = 3'd2,
		imm_j = 3'd3,
		imm_u = 3'd4
	} imm_type_e;

	// Same values as funct3 of the branch group
	typedef enum logic [2:0] {
		br_beq  = 3'b000,
		br_bne  = 3'b001,
		br_blt  = 3'b100,
		br_bge  = 3'b101,
		br_bltu = 3'b110,
		br_bgeu = 3'b111
	} branch_op_e;

	typedef enum logic {
		wb_alu  = 1'b0,	// ALU result
		wb_link = 1'b1	// PC plus 4 for JAL and JALR
	} wb_sel_e;

endpackage

/* logic/rv_regfile.sv */
module rv_regfile (
	input  logic             clk,
	input  rv_pkg::reg_idx_t rs1,
	input  rv_pkg::reg_idx_t rs2,
	input  rv_pkg::reg_idx_t rd,
	input  logic             we,
	input  rv_pkg::word_t    wdata,
	output rv_pkg::word_t    rs1_data,
	output rv_pkg::word_t    rs2_data
);
	import rv_pkg::*;

	word_t regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (we && rd != '0) begin	// x0 is never written
			regs[rd] <= wdata;
		end
	end

	// Combinational reads, x0 forced to zero
	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* run.sh */
#!/bin/sh
# Build and run the rv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_rv_core -f compile.f; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_rv_core 2>&1)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qxF "Simulation finished: PASS"; then
	exit 0
fi
exit 1

/* tb/rv_core_sva.sv */
module rv_core_sva (
	input logic          clk,
	input logic          rst,
	input logic          inst_valid,
	input rv_pkg::word_t pc,
	input logic          retire_valid
);
	timeunit 1ns;
	timeprecision 1ps;

	// Retire port is cleared by reset
	retire_low_after_reset: assert property (@(posedge clk) rst |=> !retire_valid)
		else $error("retire_valid high in the cycle after reset");

	// One retire per accepted instruction, one cycle later
	retire_follows_valid: assert property (@(posedge clk) disable iff (rst)
			!$past(rst) |-> retire_valid == $past(inst_valid))
		else $error("retire_valid does not follow inst_valid of the previous cycle");

	pc_word_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
		else $error("pc %h is not word aligned", pc);

endmodule

bind rv_core rv_core_sva u_sva (.*);

/* tb/tb_rv_core.sv */
module tb_rv_core;
	timeunit 1ns;
	timeprecision 1ps;

	import rv_pkg::*;

	localparam int SEED = 57;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_INSTS = 2000;	// Random phase including stalls
	localparam int RETIRE_TIMEOUT = 8;	// Cycles allowed for a retire to show up
	localparam int VALID_PCT = 80;
	localparam int DRIVE_DELAY = 1;	// ns after the rising edge

	typedef struct packed {
		word_t    pc;
		word_t    next_pc;
		logic     rd_we;
		reg_idx_t rd;
		word_t    rd_data;
	} retire_rec_t;

	logic     clk = 1'b0;
	logic     rst;
	inst_t    inst;
	logic     inst_valid;
	word_t    pc;
	logic     retire_valid;
	word_t    retire_pc;
	word_t    retire_next_pc;
	logic     retire_rd_we;
	reg_idx_t retire_rd;
	word_t    retire_rd_data;

	word_t       model_regs [NUM_REGS];
	word_t       model_pc;
	retire_rec_t expect_q [$];
	int          mismatch_count;
	int          other_errors;
	logic        timed_out;
	logic [6:0]  unknown_opc [4] = '{7'b0000011, 7'b0100011, 7'b0001111, 7'b1110011};

	always #5 clk = ~clk;

	rv_core UUT (
		.clk(clk), .rst(rst), .inst(inst), .inst_valid(inst_valid), .pc(pc),
		.retire_valid(retire_valid), .retire_pc(retire_pc), .retire_next_pc(retire_next_pc),
		.retire_rd_we(retire_rd_we), .retire_rd(retire_rd), .retire_rd_data(retire_rd_data)
	);

	task automatic check_word(input string what, input word_t got, input word_t exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_idx(input string what, input reg_idx_t got, input reg_idx_t exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("Mismatch at %0t: %s is x%0d, expected x%0d", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// ISA rules for the OP and OP-IMM groups
	function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
			input logic reg_form, input word_t a, input word_t b);
		logic [4:0] sh;
		word_t      res;
		sh = b[4:0];
		case (f3)
			3'b000: res = (alt && reg_form) ? a - b : a + b;
			3'b001: res = a << sh;
			3'b010: res = ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
			3'b011: res = (a < b) ? word_t'(1) : word_t'(0);
			3'b100: res = a ^ b;
			3'b101: res = alt ? word_t'($signed(a) >>> sh) : a >> sh;
			3'b110: res = a | b;
			default: res = a & b;
		endcase
		return res;
	endfunction

	function automatic logic branch_model(input logic [2:0] f3, input word_t a, input word_t b);
		case (f3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			3'b111: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	// Picks a JALR base register that holds a word-aligned value
	function automatic reg_idx_t pick_aligned_base();
		reg_idx_t cand;
		int       tries;
		for (tries = 0; tries < 8; tries++) begin
			cand = reg_idx_t'($urandom);
			if (model_regs[cand][1:0] == 2'b00) return cand;
		end
		return '0;
	endfunction

	task automatic model_execute(input inst_t ins, output retire_rec_t rec);
		opcode_e    opc;
		logic [2:0] f3;
		reg_idx_t   rd;
		word_t      a;
		word_t      b;
		word_t      imm_i;
		word_t      imm_b;
		word_t      imm_j;
		word_t      imm_u;
		opc   = opcode_e'(ins[6:0]);
		f3    = ins[14:12];
		rd    = ins[11:7];
		a     = model_regs[ins[19:15]];
		b     = model_regs[ins[24:20]];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		imm_u = {ins[31:12], 12'b0};
		rec.pc      = model_pc;
		rec.next_pc = model_pc + INST_BYTES;	// Also the no-op case
		rec.rd_we   = 1'b0;
		rec.rd      = rd;
		rec.rd_data = '0;
		case (opc)
			opc_op: begin
				rec.rd_we   = 1'b1;
				rec.rd_data = alu_model(f3, ins[30], 1'b1, a, b);
			end
			opc_op_imm: begin
				rec.rd_we   = 1'b1;
				rec.rd_data = alu_model(f3, ins[30], 1'b0, a, imm_i);
			end
			opc_lui: begin
				rec.rd_we   = 1'b1;
				rec.rd_data = imm_u;
			end
			opc_auipc: begin
				rec.rd_we   = 1'b1;
				rec.rd_data = model_pc + imm_u;
			end
			opc_jal: begin
				rec.rd_we   = 1'b1;
				rec.rd_data = model_pc + INST_BYTES;
				rec.next_pc = model_pc + imm_j;
			end
			opc_jalr: begin
				rec.rd_we   = 1'b1;
				rec.rd_data = model_pc + INST_BYTES;
				rec.next_pc = (a + imm_i) & ~word_t'(1);
			end
			opc_branch: begin
				if (branch_model(f3, a, b)) rec.next_pc = model_pc + imm_b;
			end
			default: ;
		endcase
		if (rec.rd_we && rd != '0) model_regs[rd] = rec.rd_data;
		model_pc = rec.next_pc;
	endtask

	task automatic gen_inst(output inst_t ins);
		reg_idx_t    rd;
		reg_idx_t    rs1;
		reg_idx_t    rs2;
		logic [2:0]  f3;
		logic        alt;
		logic [11:0] imm12;
		word_t       rnd;
		word_t       off;
		logic [1:0]  sel;
		rd  = reg_idx_t'($urandom);
		rs1 = reg_idx_t'($urandom);
		rs2 = reg_idx_t'($urandom);
		f3  = 3'($urandom);
		alt = 1'($urandom) && (f3 == 3'b000 || f3 == 3'b101);	// Only add/sub and srl/sra
		rnd = $urandom;
		case ($urandom_range(9))
			0, 1: ins = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, opc_op};
			2, 3: begin
				imm12 = rnd[11:0];
				if (f3 == 3'b001 || f3 == 3'b101) imm12 = {1'b0, alt, 5'b0, rnd[4:0]};
				ins = {imm12, rs1, f3, rd, opc_op_imm};
			end
			4: ins = {rnd[19:0], rd, (rnd[31] ? opc_lui : opc_auipc)};
			5: begin
				off = word_t'((int'($urandom_range(32)) - 16) * 4);
				ins = {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
			end
			6: begin
				imm12    = 12'((int'($urandom_range(16)) - 8) * 4);
				imm12[0] = rnd[0];	// Dropped by the target rule
				ins = {imm12, pick_aligned_base(), 3'b000, rd, opc_jalr};
			end
			7, 8: begin
				f3 = 3'($urandom_range(5));
				if (f3 >= 3'd2) f3 = f3 + 3'd2;	// Skip funct3 2 and 3
				if ($urandom_range(3) == 0) rs2 = rs1;	// More equal compares
				off = word_t'((int'($urandom_range(32)) - 16) * 4);
				ins = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc_branch};
			end
			default: begin
				sel = 2'($urandom_range(3));
				ins = {rnd[31:7], unknown_opc[sel]};
			end
		endcase
	endtask

	task automatic compare_retire();
		retire_rec_t rec;
		rec = expect_q.pop_front();
		check_word("retire_pc", retire_pc, rec.pc);
		check_word("retire_next_pc", retire_next_pc, rec.next_pc);
		check_flag("retire_rd_we", retire_rd_we, rec.rd_we);
		if (rec.rd_we) begin
			check_idx("retire_rd", retire_rd, rec.rd);
			check_word("retire_rd_data", retire_rd_data, rec.rd_data);
		end
		check_word("pc after retire", pc, rec.next_pc);
	endtask

	// Drives one cycle and checks what the edge produced
	task automatic run_cycle(input logic valid, input inst_t ins);
		retire_rec_t rec;
		int          waited;
		check_word("pc", pc, model_pc);
		if (valid) begin
			model_execute(ins, rec);
			expect_q.push_back(rec);
		end
		inst_valid = valid;
		inst       = ins;
		@(posedge clk);
		#DRIVE_DELAY;
		if (valid) begin
			inst_valid = 1'b0;
			waited     = 0;
			while (!retire_valid && waited < RETIRE_TIMEOUT) begin
				@(posedge clk);
				#DRIVE_DELAY;
				waited++;
			end
			if (retire_valid) begin
				compare_retire();
			end else begin
				other_errors++;
				timed_out = 1'b1;
				$display("Timeout at %0t: no retire for the instruction at pc %h", $time, rec.pc);
			end
		end else if (retire_valid) begin
			other_errors++;
			$display("Error at %0t: retire reported after a cycle without inst_valid", $time);
		end
	endtask

	initial begin
		logic  valid;
		inst_t ins;
		word_t rnd;
		rst            = 1'b1;
		inst_valid     = 1'b0;
		inst           = '0;
		mismatch_count = 0;
		other_errors   = 0;
		timed_out      = 1'b0;
		void'($urandom(SEED));
		model_pc = RESET_PC;
		for (int i = 0; i < NUM_REGS; i++) model_regs[i] = '0;
		repeat (RESET_CYCLES) begin
			@(posedge clk);
			#DRIVE_DELAY;
			check_flag("retire_valid in reset", retire_valid, 1'b0);
		end
		rst = 1'b0;
		check_word("pc after reset", pc, RESET_PC);
		repeat (3) run_cycle(1'b0, inst_t'($urandom));	// Nothing may retire yet

		// Give every register a known value before random reads
		for (int r = 1; r < NUM_REGS && !timed_out; r++) begin
			rnd = $urandom;
			run_cycle(1'b1, {rnd[19:0], reg_idx_t'(r), opc_lui});
			rnd = $urandom;
			run_cycle(1'b1, {rnd[11:0], reg_idx_t'(r), 3'b000, reg_idx_t'(r), opc_op_imm});
		end

		for (int n = 0; n < NUM_INSTS && !timed_out; n++) begin
			valid = ($urandom_range(99) < VALID_PCT);
			if (valid) gen_inst(ins);
			else ins = inst_t'($urandom);
			run_cycle(valid, ins);
		end

		if (expect_q.size() != 0) begin
			other_errors++;
			$display("Error: %0d instructions never retired", expect_q.size());
		end
		$display("Errors: %0d mismatches, %0d other errors", mismatch_count, other_errors);
		if (mismatch_count == 0 && other_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule
